/* adapt_sr_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sideband serial ring, transmit and
// receive halves on the rx osc clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module adapt_sr_top
  import sr_pkg::*;
#(
  parameter int DATA_BITS   = SR_DATA_BITS,
  parameter int HIP_BITS    = SR_HIP_BITS,
  parameter int GROUP_BITS  = SR_GROUP_BITS,
  parameter int PARITY_BITS = SR_PARITY_BITS
)
(
  input  logic                   sr_clock_rx_osc_clk,
  input  logic                   sr_reset_rx_osc_clk_rst_n,
  input  logic                   r_sr_hip_en,
  input  logic                   r_sr_parity_en,
  input  logic                   sr_transfer_en,
  input  logic [DATA_BITS-1:0]   tx_fabric_data,
  input  logic [HIP_BITS-1:0]    tx_hip_data,
  output logic                   aib_sr_data_out,
  output logic                   aib_sr_load_out,
  input  logic                   aib_sr_data_in,
  input  logic                   aib_sr_load_in,
  output logic [DATA_BITS-1:0]   rx_fabric_data,
  output logic [HIP_BITS-1:0]    rx_hip_data,
  output logic                   fabric_update_load,
  output logic [PARITY_BITS-1:0] sr_parity_error_flag
);

  logic      update_load;
  logic      check_en;
  sr_frame_t rx_frame;

  // Transmit half
  sr_load_gen #(
    .DATA_BITS (DATA_BITS),
    .HIP_BITS  (HIP_BITS)
  ) u_load_gen (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .sr_transfer_en            (sr_transfer_en),
    .load_out                  (aib_sr_load_out)
  );

  sr_serializer #(
    .DATA_BITS (DATA_BITS),
    .HIP_BITS  (HIP_BITS)
  ) u_serializer (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .r_sr_hip_en               (r_sr_hip_en),
    .r_sr_parity_en            (r_sr_parity_en),
    .load                      (aib_sr_load_out),
    .fabric_data               (tx_fabric_data),
    .hip_data                  (tx_hip_data),
    .data_out                  (aib_sr_data_out)
  );

  // Receive half
  sr_load_qualify u_load_qualify (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .load_in                   (aib_sr_load_in),
    .update_load               (update_load),
    .check_en                  (check_en)
  );

  sr_deserializer #(
    .DATA_BITS (DATA_BITS),
    .HIP_BITS  (HIP_BITS)
  ) u_deserializer (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .data_in                   (aib_sr_data_in),
    .load_in                   (aib_sr_load_in),
    .update_load               (update_load),
    .rx_frame                  (rx_frame)
  );

  sr_parity_check #(
    .DATA_BITS   (DATA_BITS),
    .GROUP_BITS  (GROUP_BITS),
    .PARITY_BITS (PARITY_BITS)
  ) u_parity_check (
    .sr_clock_rx_osc_clk       (sr_clock_rx_osc_clk),
    .sr_reset_rx_osc_clk_rst_n (sr_reset_rx_osc_clk_rst_n),
    .r_sr_hip_en               (r_sr_hip_en),
    .r_sr_parity_en            (r_sr_parity_en),
    .rx_frame                  (rx_frame),
    .update_load               (update_load),
    .check_en                  (check_en),
    .parity_error              (sr_parity_error_flag)
  );

  assign fabric_update_load = update_load;
  assign rx_fabric_data     = rx_frame.raw.data;
  assign rx_hip_data        = rx_frame.raw.hip;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the sideband ring testbench with Verilator
rm -f sim.log build.log
verilator --binary --assert -Wno-fatal -f src.f --top-module tb_adapt_sr \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_adapt_sr > sim.log 2>&1 ; cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure"; exit 1; } || true
grep -q "TEST OK" sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0

/* sr_deserializer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive shift register with gated
// parallel update
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module sr_deserializer
  import sr_pkg::*;
#(
  parameter int DATA_BITS = SR_DATA_BITS,
  parameter int HIP_BITS  = SR_HIP_BITS
)
(
  input  logic      sr_clock_rx_osc_clk,
  input  logic      sr_reset_rx_osc_clk_rst_n,
  input  logic      data_in,
  input  logic      load_in,
  input  logic      update_load,
  output sr_frame_t rx_frame
);

  localparam int FRAME_BITS = DATA_BITS + HIP_BITS;

  logic [FRAME_BITS-1:0] shift_reg;

  // Bits arrive LSB first, so enter at the top
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (!load_in)
    begin
      shift_reg <= {data_in, shift_reg[FRAME_BITS-1:1]};
    end
  end

  // Outputs only move on a gated load
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (sr_reset_rx_osc_clk_rst_n == 1'b0)
    begin
      rx_frame <= '0;
    end
    else if (load_in && update_load)
    begin
      rx_frame <= shift_reg;
    end
  end

endmodule

`default_nettype wire

/* sr_load_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ring load generator, one capture strobe
// every frame period while enabled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module sr_load_gen
  import sr_pkg::*;
#(
  parameter int DATA_BITS = SR_DATA_BITS,
  parameter int HIP_BITS  = SR_HIP_BITS
)
(
  input  logic sr_clock_rx_osc_clk,
  input  logic sr_reset_rx_osc_clk_rst_n,
  input  logic sr_transfer_en,
  output logic load_out
);

  localparam int FRAME_BITS = DATA_BITS + HIP_BITS;
  localparam int CNT_W      = $clog2(FRAME_BITS + 1);

  // Zero count is the idle state
  logic [CNT_W-1:0] bit_cnt;

  // Period is FRAME_BITS shift cycles plus the load cycle
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (sr_reset_rx_osc_clk_rst_n == 1'b0)
    begin
      bit_cnt  <= '0;
      load_out <= 1'b0;
    end
    else if (!sr_transfer_en)
    begin
      bit_cnt  <= '0;
      load_out <= 1'b0;
    end
    else if (bit_cnt == '0)
    begin
      // Start of a new frame
      bit_cnt  <= CNT_W'(FRAME_BITS);
      load_out <= 1'b1;
    end
    else
    begin
      bit_cnt  <= bit_cnt - 1'b1;
      load_out <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* sr_load_qualify.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Incoming load gate and parity checker
// qualifier
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module sr_load_qualify
(
  input  logic sr_clock_rx_osc_clk,
  input  logic sr_reset_rx_osc_clk_rst_n,
  input  logic load_in,
  output logic update_load,
  output logic check_en
);

  logic load_in_dly;
  logic load_gate;
  logic qual_dly0;

  // First load pulse may be partial, so pass only after its falling edge
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (sr_reset_rx_osc_clk_rst_n == 1'b0)
    begin
      load_in_dly <= 1'b0;
      load_gate   <= 1'b0;
    end
    else
    begin
      load_in_dly <= load_in;
      if (!load_gate)
      begin
        load_gate <= load_in_dly & ~load_in;
      end
    end
  end

  assign update_load = load_gate & load_in;

  // Two gated loads before checks begin
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (sr_reset_rx_osc_clk_rst_n == 1'b0)
    begin
      qual_dly0 <= 1'b0;
      check_en  <= 1'b0;
    end
    else
    begin
      if (!qual_dly0)
      begin
        qual_dly0 <= update_load;
      end
      if (!check_en)
      begin
        check_en <= update_load & qual_dly0;
      end
    end
  end

endmodule

`default_nettype wire

/* sr_parity_check.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-group parity checker on the
// received frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module sr_parity_check
  import sr_pkg::*;
#(
  parameter int DATA_BITS   = SR_DATA_BITS,
  parameter int GROUP_BITS  = SR_GROUP_BITS,
  parameter int PARITY_BITS = SR_PARITY_BITS
)
(
  input  logic                   sr_clock_rx_osc_clk,
  input  logic                   sr_reset_rx_osc_clk_rst_n,
  input  logic                   r_sr_hip_en,
  input  logic                   r_sr_parity_en,
  input  sr_frame_t              rx_frame,
  input  logic                   update_load,
  input  logic                   check_en,
  output logic [PARITY_BITS-1:0] parity_error
);

  // Groups that actually carry data
  localparam int CHECK_BITS = DATA_BITS / GROUP_BITS;

  logic                      mode_on;
  logic                      chk_pend;
  logic [SR_PARITY_BITS-1:0] exp_parity;
  logic [PARITY_BITS-1:0]    mismatch;
  logic [PARITY_BITS-1:0]    err_q;

  assign mode_on    = r_sr_parity_en & ~r_sr_hip_en;
  assign exp_parity = sr_group_parity(rx_frame.par.data);

  always_comb
  begin
    mismatch = '0;
    for (int g = 0; g < CHECK_BITS; g++)
    begin
      mismatch[g] = exp_parity[g] ^ rx_frame.par.parity[g];
    end
  end

  // rx_frame takes the new word on the update edge, compare one cycle on
  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (sr_reset_rx_osc_clk_rst_n == 1'b0)
    begin
      chk_pend <= 1'b0;
      err_q    <= '0;
    end
    else
    begin
      chk_pend <= update_load & check_en;
      if (!mode_on)
        err_q <= '0;
      else if (chk_pend)
        err_q <= mismatch;
    end
  end

  assign parity_error = err_q & {PARITY_BITS{mode_on}};

endmodule

`default_nettype wire

/* sr_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sideband ring package: frame geometry,
// frame decode views and group parity
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package sr_pkg;

  localparam int SR_DATA_BITS   = 24;
  localparam int SR_HIP_BITS    = 8;
  localparam int SR_GROUP_BITS  = 8;
  localparam int SR_PARITY_BITS = SR_DATA_BITS / SR_GROUP_BITS;
  localparam int SR_FRAME_BITS  = SR_DATA_BITS + SR_HIP_BITS;

  // One frame word, read either raw or with parity
  typedef union packed {
    struct packed {
      logic [SR_HIP_BITS-1:0]  hip;
      logic [SR_DATA_BITS-1:0] data;
    } raw;
    struct packed {
      logic [SR_FRAME_BITS-SR_DATA_BITS-SR_PARITY_BITS-1:0] pad;
      logic [SR_PARITY_BITS-1:0]                            parity;
      logic [SR_DATA_BITS-1:0]                              data;
    } par;
  } sr_frame_t;

  // Even parity, one bit per data group
  function automatic logic [SR_PARITY_BITS-1:0] sr_group_parity(
    input logic [SR_DATA_BITS-1:0] data
  );
    logic [SR_PARITY_BITS-1:0] par;
    par = '0;
    for (int g = 0; g < SR_PARITY_BITS; g++)
    begin
      par[g] = ^data[g*SR_GROUP_BITS +: SR_GROUP_BITS];
    end
    return par;
  endfunction

endpackage

`default_nettype wire

/* sr_serializer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transmit frame builder and LSB-first
// shift register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module sr_serializer
  import sr_pkg::*;
#(
  parameter int DATA_BITS = SR_DATA_BITS,
  parameter int HIP_BITS  = SR_HIP_BITS
)
(
  input  logic                 sr_clock_rx_osc_clk,
  input  logic                 sr_reset_rx_osc_clk_rst_n,
  input  logic                 r_sr_hip_en,
  input  logic                 r_sr_parity_en,
  input  logic                 load,
  input  logic [DATA_BITS-1:0] fabric_data,
  input  logic [HIP_BITS-1:0]  hip_data,
  output logic                 data_out
);

  localparam int FRAME_BITS = DATA_BITS + HIP_BITS;

  sr_frame_t             tx_frame;
  logic [FRAME_BITS-1:0] shift_reg;

  // Parity view only when parity is on and HIP is off
  always_comb
  begin
    tx_frame = '0;
    if (r_sr_parity_en && !r_sr_hip_en)
    begin
      tx_frame.par.pad    = '0;
      tx_frame.par.parity = sr_group_parity(fabric_data);
      tx_frame.par.data   = fabric_data;
    end
    else
    begin
      tx_frame.raw.hip  = hip_data;
      tx_frame.raw.data = fabric_data;
    end
  end

  always_ff @(posedge sr_clock_rx_osc_clk)
  begin
    if (sr_reset_rx_osc_clk_rst_n == 1'b0)
    begin
      shift_reg <= '0;
    end
    else if (load)
    begin
      shift_reg <= tx_frame;
    end
    else
    begin
      // Zeros fill in behind the last bit
      shift_reg <= {1'b0, shift_reg[FRAME_BITS-1:1]};
    end
  end

  assign data_out = shift_reg[0];

endmodule

`default_nettype wire

/* sr_vectors.txt */
# hip_en parity_en flip_index [fabric_data_hex hip_data_hex], one frame per line
# flip_index -1 sends the frame clean; missing data is filled by xorshift
0 1 -1 a5c3e1 00
0 1 -1
0 1 -1 123456 ff
0 1 -1
0 1 5
0 1 -1
0 1 13 00ff00 00
0 1 22
0 1 -1
1 0 -1 abcdef 5a
1 0 30
1 1 -1
0 0 9 0f0f0f 3c
0 0 -1
0 1 -1

/* src.f */
sr_pkg.sv
sr_load_gen.sv
sr_serializer.sv
sr_load_qualify.sv
sr_deserializer.sv
sr_parity_check.sv
adapt_sr_top.sv
tb_adapt_sr.sv

/* tb_adapt_sr.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Loopback testbench for the sideband
// serial ring, vectors from a data file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_adapt_sr
  import sr_pkg::*;
();

  localparam int PERIOD_CYC = SR_FRAME_BITS + 1;
  localparam int WAIT_LIMIT = 100;
  localparam int PAD_BITS   = SR_FRAME_BITS - SR_DATA_BITS - SR_PARITY_BITS;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      r_sr_hip_en;
  logic                      r_sr_parity_en;
  logic                      sr_transfer_en;
  logic [SR_DATA_BITS-1:0]   tx_fabric_data;
  logic [SR_HIP_BITS-1:0]    tx_hip_data;
  logic                      aib_sr_data_out;
  logic                      aib_sr_load_out;
  logic                      aib_sr_data_in;
  logic                      aib_sr_load_in;
  logic [SR_DATA_BITS-1:0]   rx_fabric_data;
  logic [SR_HIP_BITS-1:0]    rx_hip_data;
  logic                      fabric_update_load;
  logic [SR_PARITY_BITS-1:0] sr_parity_error_flag;

  // Output samples taken at each falling edge
  logic                      load_s;
  logic                      upd_s;
  logic [SR_DATA_BITS-1:0]   rx_fab_s;
  logic [SR_HIP_BITS-1:0]    rx_hip_s;
  logic [SR_PARITY_BITS-1:0] flag_s;

  int                        cyc;
  int                        last_load_cyc;
  int                        bit_pos;
  int                        cur_flip;
  int                        frame_no;
  int                        checks;
  int                        errors;
  logic [31:0]               rng;
  logic [SR_FRAME_BITS-1:0]  prev_frame;
  logic [SR_FRAME_BITS-1:0]  tx_exp;
  logic [SR_PARITY_BITS-1:0] flag_model;

  adapt_sr_top dut0 (
    .sr_clock_rx_osc_clk       (clk),
    .sr_reset_rx_osc_clk_rst_n (rst_n),
    .r_sr_hip_en               (r_sr_hip_en),
    .r_sr_parity_en            (r_sr_parity_en),
    .sr_transfer_en            (sr_transfer_en),
    .tx_fabric_data            (tx_fabric_data),
    .tx_hip_data               (tx_hip_data),
    .aib_sr_data_out           (aib_sr_data_out),
    .aib_sr_load_out           (aib_sr_load_out),
    .aib_sr_data_in            (aib_sr_data_in),
    .aib_sr_load_in            (aib_sr_load_in),
    .rx_fabric_data            (rx_fabric_data),
    .rx_hip_data               (rx_hip_data),
    .fabric_update_load        (fabric_update_load),
    .sr_parity_error_flag      (sr_parity_error_flag)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Even parity per 8-bit group, bit by bit
  function automatic logic [SR_PARITY_BITS-1:0] group_parity(
    input logic [SR_DATA_BITS-1:0] d
  );
    logic [SR_PARITY_BITS-1:0] p;
    p = '0;
    for (int i = 0; i < SR_DATA_BITS; i++)
    begin
      p[i / SR_GROUP_BITS] = p[i / SR_GROUP_BITS] ^ d[i];
    end
    return p;
  endfunction

  // Frame as it should arrive, bit error included
  function automatic logic [SR_FRAME_BITS-1:0] build_frame(
    input logic                    hip_en,
    input logic                    par_en,
    input logic [SR_DATA_BITS-1:0] fab,
    input logic [SR_HIP_BITS-1:0]  hdat,
    input int                      flip
  );
    logic [SR_FRAME_BITS-1:0] f;
    if (par_en && !hip_en)
    begin
      f = {{PAD_BITS{1'b0}}, group_parity(fab), fab};
    end
    else
    begin
      f = {hdat, fab};
    end
    if (flip >= 0 && flip < SR_FRAME_BITS)
    begin
      f[flip] = ~f[flip];
    end
    return f;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (exp === act)
    else
    begin
      errors++;
      $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  // Sample, then drive the loopback for the next cycle
  task automatic next_cycle();
    @(negedge clk);
    cyc++;
    load_s   = aib_sr_load_out;
    upd_s    = fabric_update_load;
    rx_fab_s = rx_fabric_data;
    rx_hip_s = rx_hip_data;
    flag_s   = sr_parity_error_flag;
    aib_sr_load_in = aib_sr_load_out;
    // Serial line carries the clean frame, LSB first
    if (bit_pos < SR_FRAME_BITS)
    begin
      check_value($sformatf("aib_sr_data_out bit %0d", bit_pos),
                  32'(tx_exp[bit_pos]), 32'(aib_sr_data_out));
    end
    if (bit_pos == cur_flip)
    begin
      aib_sr_data_in = ~aib_sr_data_out;
    end
    else
    begin
      aib_sr_data_in = aib_sr_data_out;
    end
    // Frame bit 0 goes out in the cycle after the load
    if (load_s)
    begin
      bit_pos = 0;
    end
    else if (bit_pos < SR_FRAME_BITS)
    begin
      bit_pos++;
    end
  endtask

  task automatic check_reset_state(input string tag);
    check_value({tag, " aib_sr_load_out"}, 32'd0, 32'(load_s));
    check_value({tag, " fabric_update_load"}, 32'd0, 32'(upd_s));
    check_value({tag, " sr_parity_error_flag"}, 32'd0, 32'(flag_s));
    check_value({tag, " rx_fabric_data"}, 32'd0, 32'(rx_fab_s));
  endtask

  task automatic wait_load(input logic check_period, output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < WAIT_LIMIT)
    begin
      next_cycle();
      n++;
      if (load_s)
      begin
        ok = 1'b1;
      end
    end
    if (!ok)
    begin
      errors++;
      $display("Timeout: no load pulse on aib_sr_load_out within %0d cycles", WAIT_LIMIT);
    end
    else
    begin
      if (check_period)
      begin
        check_value("load period", PERIOD_CYC, cyc - last_load_cyc);
      end
      last_load_cyc = cyc;
    end
  endtask

  // Send one frame and check the one before it
  task automatic run_frame(input logic hip_en, input logic par_en, input int flip,
                           input logic [SR_DATA_BITS-1:0] fab,
                           input logic [SR_HIP_BITS-1:0] hdat, output logic ok);
    logic [SR_FRAME_BITS-1:0] sent;
    string                    tag;
    wait_load(frame_no > 0, ok);
    if (ok)
    begin
      r_sr_hip_en    = hip_en;
      r_sr_parity_en = par_en;
      tx_fabric_data = fab;
      tx_hip_data    = hdat;
      cur_flip       = flip;
      sent   = build_frame(hip_en, par_en, fab, hdat, flip);
      tx_exp = build_frame(hip_en, par_en, fab, hdat, -1);
      tag    = $sformatf("load %0d", frame_no);
      next_cycle();
      check_value({tag, " fabric_update_load"}, 32'(frame_no > 0), 32'(upd_s));
      if (frame_no > 0)
      begin
        check_value({tag, " rx_fabric_data"},
                    32'(prev_frame[SR_DATA_BITS-1:0]), 32'(rx_fab_s));
        check_value({tag, " rx_hip_data"},
                    32'(prev_frame[SR_FRAME_BITS-1:SR_DATA_BITS]), 32'(rx_hip_s));
      end
      // Checks start at the third update, masked outside parity mode
      if (!par_en || hip_en)
      begin
        flag_model = '0;
      end
      else if (frame_no >= 3)
      begin
        flag_model = group_parity(prev_frame[SR_DATA_BITS-1:0])
                     ^ prev_frame[SR_DATA_BITS +: SR_PARITY_BITS];
      end
      next_cycle();
      check_value({tag, " sr_parity_error_flag"}, 32'(flag_model), 32'(flag_s));
      prev_frame = sent;
      frame_no++;
    end
  endtask

  initial
  begin
    int                      fd;
    int                      cnt;
    string                   line;
    int                      hip_v;
    int                      par_v;
    int                      flip_v;
    logic [SR_DATA_BITS-1:0] fab_v;
    logic [SR_HIP_BITS-1:0]  hdat_v;
    logic                    ok;
    rst_n          = 1'b0;
    r_sr_hip_en    = 1'b0;
    r_sr_parity_en = 1'b0;
    sr_transfer_en = 1'b0;
    tx_fabric_data = '0;
    tx_hip_data    = '0;
    aib_sr_data_in = 1'b0;
    aib_sr_load_in = 1'b0;
    cyc            = 0;
    last_load_cyc  = 0;
    bit_pos        = SR_FRAME_BITS;
    cur_flip       = -1;
    frame_no       = 0;
    checks         = 0;
    errors         = 0;
    rng            = 32'd43503;
    prev_frame     = '0;
    tx_exp         = '0;
    flag_model     = '0;
    ok             = 1'b1;
    repeat (4)
    begin
      next_cycle();
      check_reset_state("in reset");
    end
    rst_n = 1'b1;
    repeat (2)
    begin
      next_cycle();
      check_reset_state("after reset");
    end
    sr_transfer_en = 1'b1;
    fd = $fopen("sr_vectors.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open the vector file sr_vectors.txt");
      ok = 1'b0;
    end
    while (ok && !$feof(fd))
    begin
      line = "";
      cnt  = $fgets(line, fd);
      cnt  = $sscanf(line, "%d %d %d %h %h", hip_v, par_v, flip_v, fab_v, hdat_v);
      if (cnt >= 3)
      begin
        if (cnt < 5)
        begin
          rng    = xorshift32(rng);
          fab_v  = rng[SR_DATA_BITS-1:0];
          rng    = xorshift32(rng);
          hdat_v = rng[SR_HIP_BITS-1:0];
        end
        run_frame(hip_v != 0, par_v != 0, flip_v, fab_v, hdat_v, ok);
      end
    end
    if (fd != 0)
    begin
      $fclose(fd);
    end
    // One more load brings the last frame home
    if (ok)
    begin
      run_frame(r_sr_hip_en, r_sr_parity_en, -1, '0, '0, ok);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
